// File: uprocPkg.sv
// TAP state enum, instruction codes, IDCODE word, SRAM timing, widths and memory register union.
package uprocPkg;

    // IEEE 1149.1 TAP states.
    typedef enum logic [3:0] {
        exit2Dr        = 4'h0,
        exit1Dr        = 4'h1,
        shiftDr        = 4'h2,
        pauseDr        = 4'h3,
        selectIrScan   = 4'h4,
        updateDr       = 4'h5,
        captureDr      = 4'h6,
        selectDrScan   = 4'h7,
        exit2Ir        = 4'h8,
        exit1Ir        = 4'h9,
        shiftIr        = 4'hA,
        pauseIr        = 4'hB,
        runTestIdle    = 4'hC,
        updateIr       = 4'hD,
        captureIr      = 4'hE,
        testLogicReset = 4'hF
    } tapStateT;

    // Instruction register.
    localparam int irWidth = 4;
    typedef logic [irWidth-1:0] irT;

    localparam irT irIdcode    = 4'b0001;
    localparam irT irMemAccess = 4'b0010;
    localparam irT irBypass    = 4'b1111;
    // Fixed pattern shifted out of every IR scan.
    localparam irT irCapture   = 4'b0101;

    // Identification word, LSB set as 1149.1 requires.
    localparam int idWidth = 32;
    localparam logic [idWidth-1:0] idcodeValue = 32'h1A5C_0F3B;

    // Bus and memory widths.
    localparam int addrWidth = 16;
    localparam int dataWidth = 16;

    // SRAM access length in core clocks, and its counter width.
    localparam int sramWait     = 2;
    localparam int sramCntWidth = $clog2(sramWait + 1);

    // Memory access data register, MSB first, bit 0 shifted first.
    localparam int memDrWidth = 1 + addrWidth + dataWidth;

    typedef struct packed {
        logic                 wr;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] wrData;
    } memCmdT;

    typedef struct packed {
        logic                 done;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] rdData;
    } memRspT;

    // Command view on Update-DR, response view on Capture-DR.
    typedef union packed {
        memCmdT cmd;
        memRspT rsp;
    } memDrT;

endpackage

// File: synch2.sv
// Two-flop synchronizer for a single asynchronous input bit.
`timescale 1ns/1ps

module synch2 (
    input  logic clk,
    input  logic arstN,
    input  logic a,
    output logic y
);

    // First stage, may go metastable.
    logic meta;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            meta <= 1'b0;
            y    <= 1'b0;
        end else begin
            meta <= a;
            y    <= meta;
        end
    end

    // Output trails the input by exactly two clocks once out of reset.
    assert property (@(posedge clk) disable iff (!arstN)
        ($past(arstN) && $past(arstN, 2)) |-> (y == $past(a, 2)))
        else $error("synch2: output does not follow input by two clocks");

endmodule

// File: jtagTap.sv
// JTAG TAP controller with TCK edge detect, 16-state graph, instruction register and TDO launch.
`timescale 1ns/1ps

module jtagTap (
    input  logic               clk,
    input  logic               arstN,
    input  logic               tckS,
    input  logic               tmsS,
    input  logic               tdiS,
    input  logic               drTdo,
    output logic               tckRise,
    output uprocPkg::tapStateT state,
    output uprocPkg::irT       ir,
    output logic               tdo
);
    import uprocPkg::*;

    logic     tckD;
    logic     tckFall;
    tapStateT nextState;
    // IR shift stage, copied to ir on Update-IR.
    irT       irShift;

    //////////////////////////////////////////////////////////////////////
    // TCK edge detect
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tckD <= 1'b0;
        end else begin
            tckD <= tckS;
        end
    end

    // One-clock pulses on each synchronized TCK edge.
    assign tckRise = tckS & ~tckD;
    assign tckFall = ~tckS & tckD;

    //////////////////////////////////////////////////////////////////////
    // TAP state graph
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            testLogicReset: nextState = tmsS ? testLogicReset : runTestIdle;
            runTestIdle:    nextState = tmsS ? selectDrScan : runTestIdle;
            selectDrScan:   nextState = tmsS ? selectIrScan : captureDr;
            captureDr:      nextState = tmsS ? exit1Dr : shiftDr;
            shiftDr:        nextState = tmsS ? exit1Dr : shiftDr;
            exit1Dr:        nextState = tmsS ? updateDr : pauseDr;
            pauseDr:        nextState = tmsS ? exit2Dr : pauseDr;
            exit2Dr:        nextState = tmsS ? updateDr : shiftDr;
            updateDr:       nextState = tmsS ? selectDrScan : runTestIdle;
            selectIrScan:   nextState = tmsS ? testLogicReset : captureIr;
            captureIr:      nextState = tmsS ? exit1Ir : shiftIr;
            shiftIr:        nextState = tmsS ? exit1Ir : shiftIr;
            exit1Ir:        nextState = tmsS ? updateIr : pauseIr;
            pauseIr:        nextState = tmsS ? exit2Ir : pauseIr;
            exit2Ir:        nextState = tmsS ? updateIr : shiftIr;
            updateIr:       nextState = tmsS ? selectDrScan : runTestIdle;
            default:        nextState = testLogicReset;
        endcase
    end

    // State advances only on TCK rise.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= testLogicReset;
        end else if (tckRise) begin
            state <= nextState;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Instruction register
    //////////////////////////////////////////////////////////////////////

    // Capture and shift of the IR stage.
    always_ff @(posedge clk) begin
        if (tckRise) begin
            if (state == captureIr) begin
                irShift <= irCapture;
            end else if (state == shiftIr) begin
                irShift <= {tdiS, irShift[irWidth-1:1]};
            end
        end
    end

    // IDCODE is loaded on the same edge that enters Test-Logic-Reset.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ir <= irIdcode;
        end else if (tckRise) begin
            if (nextState == testLogicReset) begin
                ir <= irIdcode;
            end else if (state == updateIr) begin
                ir <= irShift;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // TDO launch
    //////////////////////////////////////////////////////////////////////

    // Launched on TCK fall so it is stable by the next rise.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tdo <= 1'b1;
        end else if (tckFall) begin
            case (state)
                shiftIr: tdo <= irShift[0];
                shiftDr: tdo <= drTdo;
                default: tdo <= 1'b1;
            endcase
        end
    end

    // Rise and fall never pulse together.
    assert property (@(posedge clk) disable iff (!arstN) !(tckRise && tckFall))
        else $error("jtagTap: TCK rise and fall in the same cycle");

    // Test-Logic-Reset always carries IDCODE.
    assert property (@(posedge clk) disable iff (!arstN)
        (state == testLogicReset) |-> (ir == irIdcode))
        else $error("jtagTap: ir is not IDCODE in Test-Logic-Reset");

endmodule

// File: debugRegs.sv
// IDCODE, BYPASS and memory access data registers with a Wishbone classic master.
`timescale 1ns/1ps

module debugRegs (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           tckRise,
    input  uprocPkg::tapStateT             state,
    input  uprocPkg::irT                   ir,
    input  logic                           tdiS,
    output logic                           drTdo,
    output logic                           wbCyc,
    output logic                           wbStb,
    output logic                           wbWe,
    output logic [uprocPkg::addrWidth-1:0] wbAdr,
    output logic [uprocPkg::dataWidth-1:0] wbDatW,
    input  logic [uprocPkg::dataWidth-1:0] wbDatR,
    input  logic                           wbAck
);
    import uprocPkg::*;

    logic [idWidth-1:0] idReg;
    logic               bypassReg;
    // Shift register and the response held for the next capture.
    memDrT              memDr;
    memDrT              memRsp;

    logic selId;
    logic selMem;
    logic drCapture;
    logic drShift;
    logic launch;

    // Instruction decode.
    assign selId  = (ir == irIdcode);
    assign selMem = (ir == irMemAccess);

    // DR actions on TCK rise.
    assign drCapture = tckRise && (state == captureDr);
    assign drShift   = tckRise && (state == shiftDr);
    // Update while busy is dropped.
    assign launch    = tckRise && (state == updateDr) && selMem && !wbCyc;

    //////////////////////////////////////////////////////////////////////
    // Data registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (drCapture) begin
            if (selId) begin
                idReg <= idcodeValue;
            end else if (selMem) begin
                memDr <= memRsp;
            end else begin
                bypassReg <= 1'b0;
            end
        end else if (drShift) begin
            if (selId) begin
                idReg <= {tdiS, idReg[idWidth-1:1]};
            end else if (selMem) begin
                memDr <= {tdiS, memDr[memDrWidth-1:1]};
            end else begin
                bypassReg <= tdiS;
            end
        end
    end

    // Serial out of the selected register.
    // BYPASS and every unused code select the bypass bit.
    always_comb begin
        case (ir)
            irIdcode:    drTdo = idReg[0];
            irMemAccess: drTdo = memDr[0];
            default:     drTdo = bypassReg;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Wishbone master
    //////////////////////////////////////////////////////////////////////

    // Address, data and direction from the command view.
    always_ff @(posedge clk) begin
        if (launch) begin
            wbWe   <= memDr.cmd.wr;
            wbAdr  <= memDr.cmd.addr;
            wbDatW <= memDr.cmd.wrData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbCyc  <= 1'b0;
            wbStb  <= 1'b0;
            memRsp <= '0;
        end else if (launch) begin
            wbCyc           <= 1'b1;
            wbStb           <= 1'b1;
            memRsp.rsp.done <= 1'b0;
        end else if (wbCyc && wbAck) begin
            wbCyc           <= 1'b0;
            wbStb           <= 1'b0;
            memRsp.rsp.done <= 1'b1;
            memRsp.rsp.addr <= wbAdr;
            // Writes echo their own data.
            memRsp.rsp.rdData <= wbWe ? wbDatW : wbDatR;
        end
    end

    // Strobe only ever rises inside a cycle.
    assert property (@(posedge clk) disable iff (!arstN) $rose(wbStb) |-> wbCyc)
        else $error("debugRegs: wbStb rose without wbCyc");

endmodule

// File: sramCtrl.sv
// Wishbone classic slave driving the external asynchronous SRAM pins and data bus.
`timescale 1ns/1ps

module sramCtrl (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           wbCyc,
    input  logic                           wbStb,
    input  logic                           wbWe,
    input  logic [uprocPkg::addrWidth-1:0] wbAdr,
    input  logic [uprocPkg::dataWidth-1:0] wbDatW,
    output logic [uprocPkg::dataWidth-1:0] wbDatR,
    output logic                           wbAck,
    output logic [uprocPkg::addrWidth-1:0] sramAddr,
    inout  wire  [uprocPkg::dataWidth-1:0] sramData,
    output logic                           sramWr,
    output logic                           sramEn
);
    import uprocPkg::*;

    // FSM is idle, access (accessQ) or ack (wbAck).
    logic                    accessQ;
    logic                    weQ;
    logic [dataWidth-1:0]    datQ;
    logic [sramCntWidth-1:0] waitCnt;
    logic                    start;
    logic                    lastAccess;

    // New request only from idle.
    assign start      = wbCyc && wbStb && !accessQ && !wbAck;
    assign lastAccess = accessQ && (waitCnt == '0);

    //////////////////////////////////////////////////////////////////////
    // Access FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            accessQ <= 1'b0;
            wbAck   <= 1'b0;
            waitCnt <= '0;
        end else begin
            wbAck <= 1'b0;
            if (start) begin
                accessQ <= 1'b1;
                waitCnt <= sramCntWidth'(sramWait - 1);
            end else if (lastAccess) begin
                accessQ <= 1'b0;
                wbAck   <= 1'b1;
            end else if (accessQ) begin
                waitCnt <= waitCnt - 1'b1;
            end
        end
    end

    // Request registered on entry, read data on the last access cycle.
    always_ff @(posedge clk) begin
        if (start) begin
            sramAddr <= wbAdr;
            datQ     <= wbDatW;
            weQ      <= wbWe;
        end
        if (lastAccess && !weQ) begin
            wbDatR <= sramData;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // SRAM pins
    //////////////////////////////////////////////////////////////////////

    assign sramEn = accessQ;
    assign sramWr = accessQ && weQ;
    // Bus is driven only while writing.
    assign sramData = (accessQ && weQ) ? datQ : 'z;

    // Ack only answers a live strobe.
    assert property (@(posedge clk) disable iff (!arstN) wbAck |-> wbStb)
        else $error("sramCtrl: wbAck without wbStb");

endmodule

// File: uProc.sv
// Processor top level: JTAG synchronizers, TAP, debug registers and SRAM controller.
`timescale 1ns/1ps

module uProc (
    // SRAM chip.
    output logic [uprocPkg::addrWidth-1:0] sramAddr,
    inout  wire  [uprocPkg::dataWidth-1:0] sramData,
    output logic                           sramWr,
    output logic                           sramEn,

    // JTAG port.
    input  logic                           tck,
    input  logic                           tdi,
    output logic                           tdo,
    input  logic                           tms,

    // Common.
    input  logic                           clk,
    input  logic                           arstN
);
    import uprocPkg::*;

    // Synchronized JTAG pins.
    logic tckS;
    logic tdiS;
    logic tmsS;

    // TAP to data registers.
    logic     tckRise;
    tapStateT state;
    irT       ir;
    logic     drTdo;

    // Wishbone.
    logic                 wbCyc;
    logic                 wbStb;
    logic                 wbWe;
    logic [addrWidth-1:0] wbAdr;
    logic [dataWidth-1:0] wbDatW;
    logic [dataWidth-1:0] wbDatR;
    logic                 wbAck;

    //////////////////////////////////////////////////////////////////////
    // Synchronizers
    //////////////////////////////////////////////////////////////////////

    synch2 i_synchTck (.clk(clk), .arstN(arstN), .a(tck), .y(tckS));
    synch2 i_synchTdi (.clk(clk), .arstN(arstN), .a(tdi), .y(tdiS));
    synch2 i_synchTms (.clk(clk), .arstN(arstN), .a(tms), .y(tmsS));

    //////////////////////////////////////////////////////////////////////
    // Debug path
    //////////////////////////////////////////////////////////////////////

    jtagTap i_jtagTap (
        .clk(clk), .arstN(arstN), .tckS(tckS), .tmsS(tmsS), .tdiS(tdiS),
        .drTdo(drTdo), .tckRise(tckRise), .state(state), .ir(ir), .tdo(tdo)
    );

    debugRegs i_debugRegs (
        .clk(clk), .arstN(arstN), .tckRise(tckRise), .state(state), .ir(ir),
        .tdiS(tdiS), .drTdo(drTdo),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck)
    );

    // External memory.
    sramCtrl i_sramCtrl (
        .clk(clk), .arstN(arstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
        .sramAddr(sramAddr), .sramData(sramData), .sramWr(sramWr), .sramEn(sramEn)
    );

endmodule

// File: tbSram.sv
// Behavioral 64K x 16 asynchronous SRAM model on the uProc memory pins.
`timescale 1ns/1ps

module tbSram (
    input  logic [uprocPkg::addrWidth-1:0] addr,
    inout  wire  [uprocPkg::dataWidth-1:0] data,
    input  logic                           wr,
    input  logic                           en
);
    import uprocPkg::*;

    // Storage array.
    logic [dataWidth-1:0] mem [0:(1 << addrWidth) - 1];

    // Power-up contents, each word derived from its full address.
    initial begin
        for (int i = 0; i < (1 << addrWidth); i++) begin
            mem[i] = dataWidth'(i) ^ 16'hC3A5;
        end
    end

    // Level-sensitive write while chip enable and write enable are both high.
    always @(en or wr or addr or data) begin
        if (en && wr) begin
            mem[addr] = data;
        end
    end

    // Read drives the bus only while enabled and not writing.
    assign data = (en && !wr) ? mem[addr] : 'z;

endmodule

// File: tbUProc.sv
// Testbench for uProc: clock, reset, JTAG bit-bang tasks, vector reader, compare tasks, timeout.
`timescale 1ns/1ps

module tbUProc;
    import uprocPkg::*;

    logic                 clk;
    logic                 arstN;
    logic                 tck;
    logic                 tdi;
    logic                 tms;
    logic                 tdo;
    logic [addrWidth-1:0] sramAddr;
    wire  [dataWidth-1:0] sramData;
    logic                 sramWr;
    logic                 sramEn;

    // Vector lines, one entry per operation.
    logic [63:0]          opQ[$];
    logic [31:0]          aQ[$];
    logic [31:0]          bQ[$];
    // Words written so far, keyed by address.
    logic [dataWidth-1:0] shadow [logic [addrWidth-1:0]];
    logic [addrWidth-1:0] lastRandAddr;
    int                   passCount;
    int                   failCount;
    int                   cycleCount;
    int                   cycleLimit;

    uProc i_uProc (
        .sramAddr(sramAddr), .sramData(sramData), .sramWr(sramWr), .sramEn(sramEn),
        .tck(tck), .tdi(tdi), .tdo(tdo), .tms(tms), .clk(clk), .arstN(arstN)
    );

    tbSram i_tbSram (.addr(sramAddr), .data(sramData), .wr(sramWr), .en(sramEn));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog on total run length.
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: the run did not end within %0d clock cycles", cycleLimit);
            $display("Verification failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkIr(input string name, input irT got, input irT exp);
        if (got === exp) begin
            passCount++;
            $display("ok   %s: %b", name, got);
        end else begin
            failCount++;
            $display("Fail at %t: %s shifted out %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got === exp) begin
            passCount++;
            $display("ok   %s: %h", name, got);
        end else begin
            failCount++;
            $display("Fail at %t: %s shifted out %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkMem(input string name, input memDrT got, input memDrT exp);
        if (got === exp) begin
            passCount++;
            $display("ok   %s: addr %h data %h", name, got.rsp.addr, got.rsp.rdData);
        end else begin
            failCount++;
            $display("Fail at %t: %s done %b addr %h data %h, expected done %b addr %h data %h",
                $time, name, got.rsp.done, got.rsp.addr, got.rsp.rdData,
                exp.rsp.done, exp.rsp.addr, exp.rsp.rdData);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // JTAG bit-bang
    //////////////////////////////////////////////////////////////////////

    // One TCK period, 4 clocks low then 4 clocks high.
    task automatic tckPulse(input logic tmsV, input logic tdiV, output logic tdoV);
        @(posedge clk);
        tck <= 1'b0;
        tms <= tmsV;
        tdi <= tdiV;
        repeat (3) @(posedge clk);
        // Sampled in the clock before the rise.
        @(negedge clk);
        tdoV = tdo;
        @(posedge clk);
        tck <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    // Full IR or DR scan from Run-Test/Idle back to Run-Test/Idle.
    task automatic scan(input logic isIr, input int nBits, input logic [63:0] din,
                        output logic [63:0] dout);
        logic b;
        dout = '0;
        tckPulse(1'b1, 1'b0, b);
        if (isIr) begin
            tckPulse(1'b1, 1'b0, b);
        end
        // Capture, then into Shift.
        tckPulse(1'b0, 1'b0, b);
        tckPulse(1'b0, 1'b0, b);
        for (int i = 0; i < nBits; i++) begin
            tckPulse(i == nBits - 1, din[i], b);
            dout[i] = b;
        end
        // Exit1 to Update, Update to Run-Test/Idle.
        tckPulse(1'b1, 1'b0, b);
        tckPulse(1'b0, 1'b0, b);
    endtask

    task automatic applyReset();
        logic b;
        arstN <= 1'b0;
        tck   <= 1'b0;
        tms   <= 1'b1;
        tdi   <= 1'b0;
        repeat (16) @(posedge clk);
        arstN <= 1'b1;
        repeat (4) @(posedge clk);
        // Out of Test-Logic-Reset.
        tckPulse(1'b0, 1'b0, b);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory access
    //////////////////////////////////////////////////////////////////////

    // One MEMACCESS scan, then 11 idle TCKs for the bus cycle.
    task automatic memScan(input logic wr, input logic [15:0] a, input logic [15:0] d,
                           output memDrT rsp);
        memDrT       c;
        logic [63:0] dout;
        logic        b;
        c.cmd.wr     = wr;
        c.cmd.addr   = a;
        c.cmd.wrData = d;
        scan(1'b0, memDrWidth, 64'(c), dout);
        rsp = dout[memDrWidth-1:0];
        repeat (11) tckPulse(1'b0, 1'b0, b);
    endtask

    task automatic memWrite(input logic [15:0] a, input logic [15:0] d);
        memDrT rsp;
        memDrT got;
        memDrT exp;
        memScan(1'b1, a, d, rsp);
        // Contents seen through the SRAM model.
        got.rsp = {1'b1, a, i_tbSram.mem[a]};
        exp.rsp = {1'b1, a, d};
        checkMem("sram write", got, exp);
        shadow[a] = d;
    endtask

    task automatic memRead(input logic [15:0] a, input logic [15:0] fileD);
        memDrT rsp;
        memDrT exp;
        exp.rsp = {1'b1, a, shadow.exists(a) ? shadow[a] : fileD};
        if (shadow.exists(a) && shadow[a] !== fileD) begin
            failCount++;
            $display("Vector file expects %h at %h but %h was written there", fileD, a, shadow[a]);
        end
        // Second scan captures the response of the first.
        memScan(1'b0, a, 16'h0000, rsp);
        memScan(1'b0, a, 16'h0000, rsp);
        checkMem("mem read", rsp, exp);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Vector file and run
    //////////////////////////////////////////////////////////////////////

    function automatic bit loadVectors();
        int          fd;
        int          n;
        string       line;
        logic [63:0] op;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("jtagVectors.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while ($fgets(line, fd) > 0) begin
            op = '0;
            a  = '0;
            b  = '0;
            n  = $sscanf(line, "%s %h %h", op, a, b);
            // Comment lines start with a hash.
            if (n >= 1 && line.getc(0) != "#") begin
                opQ.push_back(op);
                aQ.push_back(a);
                bQ.push_back(b);
            end
        end
        $fclose(fd);
        return 1'b1;
    endfunction

    task automatic runVector(input logic [63:0] op, input logic [31:0] a, input logic [31:0] b);
        logic [63:0] dout;
        logic        t;
        if (op == "reset") begin
            applyReset();
        end else if (op == "ir") begin
            scan(1'b1, irWidth, 64'(a), dout);
            checkIr("ir scan", dout[irWidth-1:0], b[irWidth-1:0]);
        end else if (op == "idcode") begin
            scan(1'b0, 32, 64'd0, dout);
            checkWord("idcode", dout[31:0], a);
        end else if (op == "bypass") begin
            // One-bit delay with a leading zero.
            scan(1'b0, 17, 64'(a[15:0]), dout);
            checkWord("bypass", dout[31:0], {15'd0, a[15:0], 1'b0});
        end else if (op == "tlr") begin
            repeat (5) tckPulse(1'b1, 1'b0, t);
            tckPulse(1'b0, 1'b0, t);
        end else if (op == "write") begin
            memWrite(a[15:0], b[15:0]);
        end else if (op == "read") begin
            memRead(a[15:0], b[15:0]);
        end else if (op == "wrand") begin
            lastRandAddr = 16'($urandom());
            memWrite(lastRandAddr, 16'($urandom()));
        end else if (op == "rdrand") begin
            memRead(lastRandAddr, shadow[lastRandAddr]);
        end else begin
            failCount++;
            $display("Unknown operation in the vector file: %s", op);
        end
    endtask

    initial begin
        bit loaded;
        arstN      = 1'b0;
        tck        = 1'b0;
        tdi        = 1'b0;
        tms        = 1'b1;
        passCount  = 0;
        failCount  = 0;
        cycleLimit = 0;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'hb97d_39d9));
        loaded = loadVectors();
        if (!loaded) begin
            failCount++;
            $display("Could not open the vector file jtagVectors.txt");
        end else begin
            // 400 clocks per vector line.
            cycleLimit = 400 * opQ.size();
            @(posedge clk);
            applyReset();
            foreach (opQ[i]) begin
                runVector(opQ[i], aQ[i], bQ[i]);
            end
        end
        $display("Checks passed: %0d, checks failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: src.f
uprocPkg.sv
synch2.sv
jtagTap.sv
debugRegs.sv
sramCtrl.sv
uProc.sv
tbSram.sv
tbUProc.sv

// File: run.sh
#!/bin/sh
# Compile the RTL and testbench with Verilator, run the simulation, then grade the log.
rm -rf obj_dir sim.log build.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tbUProc \
    -f src.f -o simUProc > build.log 2>&1 &&
./obj_dir/simUProc > sim.log 2>&1 ||
echo "Build or simulation stopped with an error, see build.log and sim.log"
grep -q "^Verification passed$" sim.log &&
echo "Simulation run graded as passing" ||
{ echo "Simulation run graded as failing, see sim.log"; exit 1; }

// File: jtagVectors.txt
# One operation per line: op, then up to two hex fields a and b.
# ir code capture | idcode expected | bypass pattern | write addr data | read addr expected
# reset, tlr, wrand and rdrand take no fields; wrand and rdrand use a random address and word.
idcode 1A5C0F3B
ir 1 5
idcode 1A5C0F3B
ir F 5
tlr
idcode 1A5C0F3B
ir F 5
bypass A5C3
bypass 0001
ir 7 5
bypass 8E71
ir 0 5
bypass 3C3C
tlr
idcode 1A5C0F3B
ir 2 5
write 1234 BEEF
write 0000 0001
write FFFF 8000
read 1234 BEEF
read 0000 0001
read FFFF 8000
wrand
rdrand
write 1234 5A5A
read 1234 5A5A
ir 2 5
reset
idcode 1A5C0F3B
ir F 5
bypass FFFF
